// ==== include/rv_core_cfg.svh ====
`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

// data and address width
`define RV_XLEN 32

// architectural registers, x0 included
`define RV_REG_COUNT 32

`define RV_RESET_PC 32'h0000_0000

// addi x0, x0, 0
`define RV_NOP 32'h0000_0013

`endif

// ==== verilog/rv_core_pkg.sv ====
`default_nettype none

`include "rv_core_cfg.svh"

package rv_core_pkg;

    typedef logic [`RV_XLEN-1:0] xlen_t;
    typedef logic [4:0] reg_idx_t;

    // major opcode, instr[6:2]
    typedef enum logic [4:0] {
        opc_op_imm = 5'b00100,
        opc_op     = 5'b01100,
        opc_lui    = 5'b01101,
        opc_branch = 5'b11000,
        opc_jal    = 5'b11011
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_sll    = 4'd2,
        alu_slt    = 4'd3,
        alu_sltu   = 4'd4,
        alu_xor    = 4'd5,
        alu_srl    = 4'd6,
        alu_sra    = 4'd7,
        alu_or     = 4'd8,
        alu_and    = 4'd9,
        alu_pass_b = 4'd10
    } alu_op_e;

    // ------------------------------------------------------------
    // stage payloads
    // ------------------------------------------------------------

    typedef struct packed {
        logic     valid;
        xlen_t    pc;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        logic     wr;
        xlen_t    imm;      // already sign extended
        logic     imm_sel;  // alu b from imm
        alu_op_e  alu_op;
        logic [2:0] funct3; // branch condition
        logic     branch;
        logic     jal;
    } if_id_t;

    typedef struct packed {
        if_id_t ctl;
        xlen_t  op1;
        xlen_t  op2;
    } id_ex_t;

    typedef struct packed {
        logic     valid;
        xlen_t    pc;
        reg_idx_t rd;
        logic     wr;
        xlen_t    result;
        logic     taken;
        xlen_t    target;
    } ex_wb_t;

endpackage

`default_nettype wire

// ==== verilog/rv_stage_reg.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv_stage_reg #(
    parameter type payload_t = logic
) (
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire logic     flush_i,
    input  wire logic     stall_i,
    input  wire logic     bubble_i,
    input  wire payload_t d_i,
    output payload_t      q_o
);

    // flush beats stall, stall beats bubble
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q_o <= '0;
        end else if (flush_i) begin
            q_o <= '0;
        end else if (stall_i) begin
            q_o <= q_o;
        end else if (bubble_i) begin
            q_o <= '0; // empty slot, valid low
        end else begin
            q_o <= d_i;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/rv_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rv_core_cfg.svh"

module rv_decode (
    input  wire rv_core_pkg::xlen_t instr_i,
    input  wire rv_core_pkg::xlen_t pc_i,
    output rv_core_pkg::if_id_t     payload_o
);

    rv_core_pkg::alu_op_e arith_op;

    // funct3 to alu op, shared by OP and OP_IMM
    always_comb begin
        case (instr_i[14:12])
            3'b000: arith_op = (instr_i[5] && instr_i[30]) ? rv_core_pkg::alu_sub
                                                            : rv_core_pkg::alu_add;
            3'b001: arith_op = rv_core_pkg::alu_sll;
            3'b010: arith_op = rv_core_pkg::alu_slt;
            3'b011: arith_op = rv_core_pkg::alu_sltu;
            3'b100: arith_op = rv_core_pkg::alu_xor;
            3'b101: arith_op = instr_i[30] ? rv_core_pkg::alu_sra : rv_core_pkg::alu_srl;
            3'b110: arith_op = rv_core_pkg::alu_or;
            default: arith_op = rv_core_pkg::alu_and;
        endcase
    end

    always_comb begin
        payload_o        = '0;
        payload_o.valid  = (instr_i != `RV_NOP); // canonical nop never retires
        payload_o.pc     = pc_i;
        payload_o.funct3 = instr_i[14:12];
        case (instr_i[6:2])
            rv_core_pkg::opc_op: begin
                payload_o.rs1    = instr_i[19:15];
                payload_o.rs2    = instr_i[24:20];
                payload_o.rd     = instr_i[11:7];
                payload_o.wr     = (instr_i[11:7] != 5'd0);
                payload_o.alu_op = arith_op;
            end
            rv_core_pkg::opc_op_imm: begin
                payload_o.rs1     = instr_i[19:15];
                payload_o.rd      = instr_i[11:7];
                payload_o.wr      = (instr_i[11:7] != 5'd0);
                payload_o.imm     = {{20{instr_i[31]}}, instr_i[31:20]}; // shamt in [4:0]
                payload_o.imm_sel = 1'b1;
                payload_o.alu_op  = arith_op;
            end
            rv_core_pkg::opc_lui: begin
                payload_o.rd      = instr_i[11:7];
                payload_o.wr      = (instr_i[11:7] != 5'd0);
                payload_o.imm     = {instr_i[31:12], 12'd0};
                payload_o.imm_sel = 1'b1;
                payload_o.alu_op  = rv_core_pkg::alu_pass_b;
            end
            rv_core_pkg::opc_branch: begin
                payload_o.rs1    = instr_i[19:15];
                payload_o.rs2    = instr_i[24:20];
                payload_o.imm    = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25],
                                    instr_i[11:8], 1'b0};
                payload_o.alu_op = rv_core_pkg::alu_sub; // flags do the compare
                payload_o.branch = 1'b1;
            end
            rv_core_pkg::opc_jal: begin
                payload_o.rd  = instr_i[11:7];
                payload_o.wr  = (instr_i[11:7] != 5'd0);
                payload_o.imm = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20],
                                 instr_i[30:21], 1'b0};
                payload_o.jal = 1'b1;
            end
            default: ; // unsupported, passes through with no write
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/rv_regfile.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rv_core_cfg.svh"

module rv_regfile (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire rv_core_pkg::reg_idx_t rs1_i,
    input  wire rv_core_pkg::reg_idx_t rs2_i,
    input  wire rv_core_pkg::reg_idx_t rd_i,
    input  wire logic                  wr_i,
    input  wire rv_core_pkg::xlen_t    wrdata_i,
    output rv_core_pkg::xlen_t         r1_o,
    output rv_core_pkg::xlen_t         r2_o
);

    rv_core_pkg::xlen_t regs [1:`RV_REG_COUNT-1]; // no storage for x0

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_i && rd_i != 5'd0) begin
            regs[rd_i] <= wrdata_i;
        end
    end

    assign r1_o = (rs1_i == 5'd0) ? '0 : regs[rs1_i];
    assign r2_o = (rs2_i == 5'd0) ? '0 : regs[rs2_i];

endmodule

`default_nettype wire

// ==== verilog/rv_alu.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rv_core_cfg.svh"

module rv_alu (
    input  wire rv_core_pkg::alu_op_e op_i,
    input  wire rv_core_pkg::xlen_t   a_i,
    input  wire rv_core_pkg::xlen_t   b_i,
    input  wire logic [2:0]           funct3_i,
    output rv_core_pkg::xlen_t        result_o,
    output logic                      cond_o
);

    logic [`RV_XLEN:0] diff; // extra bit is the carry out
    logic carry, zero, neg, ovf;
    logic [4:0] shamt;

    // a - b as a + ~b + 1, carry set means no borrow
    assign diff  = {1'b0, a_i} + {1'b0, ~b_i} + {{`RV_XLEN{1'b0}}, 1'b1};
    assign carry = diff[`RV_XLEN];
    assign zero  = (diff[`RV_XLEN-1:0] == '0);
    assign neg   = diff[`RV_XLEN-1];
    assign ovf   = (a_i[`RV_XLEN-1] != b_i[`RV_XLEN-1]) && (neg != a_i[`RV_XLEN-1]);
    assign shamt = b_i[4:0];

    always_comb begin
        case (op_i)
            rv_core_pkg::alu_add:  result_o = a_i + b_i;
            rv_core_pkg::alu_sub:  result_o = diff[`RV_XLEN-1:0];
            rv_core_pkg::alu_sll:  result_o = a_i << shamt;
            rv_core_pkg::alu_slt:  result_o = {{(`RV_XLEN-1){1'b0}}, neg ^ ovf};
            rv_core_pkg::alu_sltu: result_o = {{(`RV_XLEN-1){1'b0}}, ~carry};
            rv_core_pkg::alu_xor:  result_o = a_i ^ b_i;
            rv_core_pkg::alu_srl:  result_o = a_i >> shamt;
            rv_core_pkg::alu_sra:  result_o = $signed(a_i) >>> shamt;
            rv_core_pkg::alu_or:   result_o = a_i | b_i;
            rv_core_pkg::alu_and:  result_o = a_i & b_i;
            default:               result_o = b_i; // pass b
        endcase
    end

    // branch condition from the subtract flags
    always_comb begin
        case (funct3_i)
            3'b000:  cond_o = zero;         // beq
            3'b001:  cond_o = ~zero;        // bne
            3'b100:  cond_o = neg ^ ovf;    // blt
            3'b101:  cond_o = ~(neg ^ ovf); // bge
            3'b110:  cond_o = ~carry;       // bltu
            3'b111:  cond_o = carry;        // bgeu
            default: cond_o = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/rv_hazard_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv_hazard_unit (
    input  wire rv_core_pkg::reg_idx_t rs1_i,
    input  wire rv_core_pkg::reg_idx_t rs2_i,
    input  wire rv_core_pkg::reg_idx_t ex_rd_i,
    input  wire logic                  ex_wr_i,
    input  wire rv_core_pkg::reg_idx_t wb_rd_i,
    input  wire logic                  wb_wr_i,
    input  wire rv_core_pkg::xlen_t    wb_data_i,
    input  wire logic                  wb_redirect_i,
    input  wire rv_core_pkg::xlen_t    r1_i,
    input  wire rv_core_pkg::xlen_t    r2_i,
    output rv_core_pkg::xlen_t         op1_o,
    output rv_core_pkg::xlen_t         op2_o,
    output logic                       flush_o,
    output logic                       stall_o,
    output logic                       bubble_o
);

    logic fwd1, fwd2;
    logic raw_ex; // producer still in execute, result not ready

    // ------------------------------------------------------------
    // forwarding from writeback
    // ------------------------------------------------------------
    assign fwd1  = wb_wr_i && rs1_i != 5'd0 && rs1_i == wb_rd_i;
    assign fwd2  = wb_wr_i && rs2_i != 5'd0 && rs2_i == wb_rd_i;
    assign op1_o = fwd1 ? wb_data_i : r1_i;
    assign op2_o = fwd2 ? wb_data_i : r2_i;

    // ------------------------------------------------------------
    // stall and bubble
    // ------------------------------------------------------------
    assign raw_ex = ex_wr_i && ex_rd_i != 5'd0 &&
                    (rs1_i == ex_rd_i || rs2_i == ex_rd_i);

    assign flush_o  = wb_redirect_i;
    assign stall_o  = raw_ex && !wb_redirect_i; // redirect wins
    assign bubble_o = raw_ex && !wb_redirect_i;

endmodule

`default_nettype wire

// ==== verilog/rv_core.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rv_core_cfg.svh"

module rv_core (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    output rv_core_pkg::xlen_t         imem_addr_o,
    input  wire rv_core_pkg::xlen_t    imem_data_i,
    output logic                       retire_o,
    output rv_core_pkg::xlen_t         retire_pc_o,
    output rv_core_pkg::reg_idx_t      retire_rd_o,
    output rv_core_pkg::xlen_t         retire_data_o
);

    rv_core_pkg::xlen_t   pc_q;
    rv_core_pkg::if_id_t  if_id_d, if_id_q;
    rv_core_pkg::id_ex_t  id_ex_d, id_ex_q;
    rv_core_pkg::ex_wb_t  ex_wb_d, ex_wb_q;
    logic                 flush, stall, bubble;
    rv_core_pkg::xlen_t   rf_r1, rf_r2, op1, op2;
    rv_core_pkg::xlen_t   alu_b, alu_result, ex_pc_plus4;
    logic                 alu_cond;

    // ------------------------------------------------------------
    // fetch, predict not taken
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= `RV_RESET_PC;
        end else if (flush) begin
            pc_q <= ex_wb_q.target; // redirect from writeback
        end else if (!stall) begin
            pc_q <= pc_q + 32'd4;
        end
    end

    assign imem_addr_o = pc_q;

    rv_decode decode_u0 (.instr_i(imem_data_i), .pc_i(pc_q), .payload_o(if_id_d));

    rv_stage_reg #(.payload_t(rv_core_pkg::if_id_t)) if_id_u0 (
        .clk(clk), .rst_n(rst_n), .flush_i(flush), .stall_i(stall), .bubble_i(1'b0),
        .d_i(if_id_d), .q_o(if_id_q)
    );

    // ------------------------------------------------------------
    // decode, operand read
    // ------------------------------------------------------------
    rv_regfile regfile_u0 (
        .clk(clk), .rst_n(rst_n),
        .rs1_i(if_id_q.rs1), .rs2_i(if_id_q.rs2),
        .rd_i(ex_wb_q.rd), .wr_i(ex_wb_q.wr), .wrdata_i(ex_wb_q.result),
        .r1_o(rf_r1), .r2_o(rf_r2)
    );

    rv_hazard_unit hazard_u0 (
        .rs1_i(if_id_q.rs1), .rs2_i(if_id_q.rs2),
        .ex_rd_i(id_ex_q.ctl.rd), .ex_wr_i(id_ex_q.ctl.wr),
        .wb_rd_i(ex_wb_q.rd), .wb_wr_i(ex_wb_q.wr), .wb_data_i(ex_wb_q.result),
        .wb_redirect_i(ex_wb_q.valid && ex_wb_q.taken),
        .r1_i(rf_r1), .r2_i(rf_r2), .op1_o(op1), .op2_o(op2),
        .flush_o(flush), .stall_o(stall), .bubble_o(bubble)
    );

    always_comb begin
        id_ex_d.ctl = if_id_q;
        id_ex_d.op1 = op1;
        id_ex_d.op2 = op2;
    end

    rv_stage_reg #(.payload_t(rv_core_pkg::id_ex_t)) id_ex_u0 (
        .clk(clk), .rst_n(rst_n), .flush_i(flush), .stall_i(1'b0), .bubble_i(bubble),
        .d_i(id_ex_d), .q_o(id_ex_q)
    );

    // ------------------------------------------------------------
    // execute
    // ------------------------------------------------------------
    assign alu_b       = id_ex_q.ctl.imm_sel ? id_ex_q.ctl.imm : id_ex_q.op2;
    assign ex_pc_plus4 = id_ex_q.ctl.pc + 32'd4;

    rv_alu alu_u0 (
        .op_i(id_ex_q.ctl.alu_op), .a_i(id_ex_q.op1), .b_i(alu_b),
        .funct3_i(id_ex_q.ctl.funct3), .result_o(alu_result), .cond_o(alu_cond)
    );

    always_comb begin
        ex_wb_d        = '0;
        ex_wb_d.valid  = id_ex_q.ctl.valid;
        ex_wb_d.pc     = id_ex_q.ctl.pc;
        ex_wb_d.rd     = id_ex_q.ctl.rd;
        ex_wb_d.wr     = id_ex_q.ctl.wr;
        ex_wb_d.result = id_ex_q.ctl.jal ? ex_pc_plus4 : alu_result; // lui via pass b
        ex_wb_d.taken  = id_ex_q.ctl.valid &&
                         (id_ex_q.ctl.jal || (id_ex_q.ctl.branch && alu_cond));
        ex_wb_d.target = ex_wb_d.taken ? id_ex_q.ctl.pc + id_ex_q.ctl.imm : ex_pc_plus4;
    end

    rv_stage_reg #(.payload_t(rv_core_pkg::ex_wb_t)) ex_wb_u0 (
        .clk(clk), .rst_n(rst_n), .flush_i(flush), .stall_i(1'b0), .bubble_i(1'b0),
        .d_i(ex_wb_d), .q_o(ex_wb_q)
    );

    // writeback, reported as retire
    assign retire_o      = ex_wb_q.valid;
    assign retire_pc_o   = ex_wb_q.pc;
    assign retire_rd_o   = ex_wb_q.wr ? ex_wb_q.rd : 5'd0;
    assign retire_data_o = ex_wb_q.result;

endmodule

`default_nettype wire

// ==== sim/tb_rv_core.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rv_core_cfg.svh"

module tb_rv_core;

    localparam int prog_words = 64;
    localparam int watchdog_cycles = prog_words * 6 + 20; // slowest path per instruction
    localparam rv_core_pkg::xlen_t final_pc = 32'((prog_words - 1) * 4);

    logic                  clk;
    logic                  rst_n;
    rv_core_pkg::xlen_t    imem_addr;
    rv_core_pkg::xlen_t    imem_data;
    logic                  retire;
    rv_core_pkg::xlen_t    retire_pc;
    rv_core_pkg::reg_idx_t retire_rd;
    rv_core_pkg::xlen_t    retire_data;

    rv_core_pkg::xlen_t prog [0:prog_words-1];
    rv_core_pkg::xlen_t ref_regs [0:31]; // architectural state of the model
    rv_core_pkg::xlen_t ref_pc;
    integer seed = 32'h4ae8_6c12;
    int errors = 0;
    int checks = 0;
    int taken_count = 0;
    int jump_count = 0;
    logic done = 1'b0;
    logic redirect_due = 1'b0;      // target fetch expected on the next falling edge
    rv_core_pkg::xlen_t redirect_pc;

    rv_core rv_core_i (
        .clk(clk), .rst_n(rst_n),
        .imem_addr_o(imem_addr), .imem_data_i(imem_data),
        .retire_o(retire), .retire_pc_o(retire_pc),
        .retire_rd_o(retire_rd), .retire_data_o(retire_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // instruction memory, answers in the same cycle
    always_comb begin
        if (imem_addr < 32'(prog_words * 4)) begin
            imem_data = prog[imem_addr[7:2]];
        end else begin
            imem_data = `RV_NOP; // past the end, never retires
        end
    end

    // ------------------------------------------------------------
    // program generation
    // ------------------------------------------------------------
    function automatic int unsigned rand_below(input int unsigned n);
        int unsigned r;
        r = $unsigned($random(seed));
        return r % n;
    endfunction

    task automatic build_program();
        int unsigned kind;
        int unsigned cond;
        int unsigned span;
        int unsigned off;
        logic [31:0] rnd;
        logic [2:0] f3;
        logic [6:0] f7;
        rv_core_pkg::reg_idx_t rd, rs1, rs2;
        for (int i = 0; i < prog_words - 1; i++) begin
            rnd  = $random(seed);
            kind = rand_below(10);
            rd   = {2'b00, rnd[9:7]}; // x0..x7 keeps dependences frequent
            rs1  = {2'b00, rnd[17:15]};
            rs2  = {2'b00, rnd[22:20]};
            f3   = rnd[14:12];
            f7   = (rnd[30] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
            span = prog_words - 1 - i;
            if (span > 8) begin
                span = 8;
            end
            off = (1 + rand_below(span)) * 4; // forward only, stays inside the program
            if (kind < 3) begin
                prog[i] = {f7, rs2, rs1, f3, rd, 7'b0110011};
            end else if (kind < 6) begin
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    prog[i] = {f7, rnd[24:20], rs1, f3, rd, 7'b0010011}; // shift by shamt
                end else begin
                    prog[i] = {rnd[31:20], rs1, f3, rd, 7'b0010011};
                end
            end else if (kind == 6) begin
                prog[i] = {rnd[31:12], rd, 7'b0110111};
            end else if (kind < 9) begin
                cond = rand_below(6);
                f3   = (cond < 2) ? cond[2:0] : cond[2:0] + 3'd2;
                prog[i] = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
            end else begin
                prog[i] = {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
            end
            if (prog[i] == `RV_NOP) begin
                prog[i] = 32'h0010_0013; // addi x0, x0, 1
            end
        end
        prog[prog_words-1] = 32'h0000_006f; // jal x0, 0
    endtask

    // ------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------
    function automatic rv_core_pkg::xlen_t arith(input logic [2:0] f3, input logic alt,
                                                 input rv_core_pkg::xlen_t a,
                                                 input rv_core_pkg::xlen_t b);
        rv_core_pkg::xlen_t r;
        case (f3)
            3'd0: r = alt ? a - b : a + b;
            3'd1: r = a << b[4:0];
            3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: r = (a < b) ? 32'd1 : 32'd0;
            3'd4: r = a ^ b;
            3'd5: begin
                if (alt) begin
                    r = $signed(a) >>> b[4:0];
                end else begin
                    r = a >> b[4:0];
                end
            end
            3'd6: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input rv_core_pkg::xlen_t a,
                                          input rv_core_pkg::xlen_t b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    // one instruction per retire strobe
    task automatic step_reference(output rv_core_pkg::xlen_t exp_pc,
                                  output rv_core_pkg::reg_idx_t exp_rd,
                                  output rv_core_pkg::xlen_t exp_data);
        rv_core_pkg::xlen_t instr, a, b, res, next_pc;
        logic writes;
        instr   = prog[ref_pc[7:2]];
        a       = ref_regs[instr[19:15]];
        b       = ref_regs[instr[24:20]];
        res     = '0;
        writes  = 1'b1;
        next_pc = ref_pc + 32'd4;
        case (instr[6:0])
            7'b0110011: res = arith(instr[14:12], instr[30], a, b);
            7'b0010011: res = arith(instr[14:12], instr[30] && instr[14:12] == 3'd5, a,
                                    {{20{instr[31]}}, instr[31:20]});
            7'b0110111: res = {instr[31:12], 12'd0};
            7'b1100011: begin
                writes = 1'b0;
                if (branch_taken(instr[14:12], a, b)) begin
                    next_pc = ref_pc + {{20{instr[31]}}, instr[7], instr[30:25],
                                        instr[11:8], 1'b0};
                    taken_count++;
                end
            end
            default: begin // jal, the only other opcode generated
                res     = ref_pc + 32'd4;
                next_pc = ref_pc + {{12{instr[31]}}, instr[19:12], instr[20],
                                    instr[30:21], 1'b0};
                jump_count++;
            end
        endcase
        exp_pc   = ref_pc;
        exp_rd   = (writes && instr[11:7] != 5'd0) ? instr[11:7] : 5'd0;
        exp_data = res;
        if (exp_rd != 5'd0) begin
            ref_regs[exp_rd] = res;
        end
        ref_pc = next_pc;
    endtask

    task automatic check_pc(input rv_core_pkg::xlen_t got, input rv_core_pkg::xlen_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at time %0t: retired pc %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_fetch(input rv_core_pkg::xlen_t got, input rv_core_pkg::xlen_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at time %0t: fetch address %h after redirect, expected %h",
                     $time, got, exp);
        end
    endtask

    task automatic check_write(input rv_core_pkg::reg_idx_t got_rd,
                               input rv_core_pkg::xlen_t got_data,
                               input rv_core_pkg::reg_idx_t exp_rd,
                               input rv_core_pkg::xlen_t exp_data);
        checks++;
        if (got_rd !== exp_rd) begin
            errors++;
            $display("error at time %0t: retired rd x%0d, expected x%0d", $time, got_rd, exp_rd);
        end else if (exp_rd != 5'd0 && got_data !== exp_data) begin
            errors++;
            $display("error at time %0t: x%0d written with %h, expected %h",
                     $time, got_rd, got_data, exp_data);
        end
    endtask

    // outputs settle after the rising edge, so look at them on the falling one
    always @(negedge clk) begin : retire_monitor
        rv_core_pkg::xlen_t exp_pc, exp_data;
        rv_core_pkg::reg_idx_t exp_rd;
        int redirects_before;
        if (redirect_due) begin
            check_fetch(imem_addr, redirect_pc);
            redirect_due = 1'b0;
        end
        if (!rst_n) begin
            if (retire !== 1'b0) begin
                errors++;
                $display("error at time %0t: retire strobe high during reset", $time);
            end
        end else if (retire === 1'b1 && !done) begin
            redirects_before = taken_count + jump_count;
            step_reference(exp_pc, exp_rd, exp_data);
            check_pc(retire_pc, exp_pc);
            check_write(retire_rd, retire_data, exp_rd, exp_data);
            if (taken_count + jump_count != redirects_before) begin
                redirect_due = 1'b1; // target fetched in the cycle after retire
                redirect_pc  = ref_pc;
            end
            if (exp_pc == final_pc) begin
                done = 1'b1;
            end
        end
    end

    initial begin
        rst_n = 1'b0;
        for (int r = 0; r < 32; r++) begin
            ref_regs[r] = '0;
        end
        ref_pc = `RV_RESET_PC;
        build_program();
        repeat (4) @(negedge clk);
        rst_n <= 1'b1;
        wait (done);
        repeat (2) @(negedge clk);
        $display("taken branches: %0d, jumps: %0d", taken_count, jump_count);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // watchdog on rising edges, the main flow ends on falling ones
    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: final self-loop not retired within %0d cycles", watchdog_cycles);
        $display("checks: %0d, errors: %0d", checks, errors);
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+include
verilog/rv_core_pkg.sv
verilog/rv_stage_reg.sv
verilog/rv_decode.sv
verilog/rv_regfile.sv
verilog/rv_alu.sv
verilog/rv_hazard_unit.sv
verilog/rv_core.sv
sim/tb_rv_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the rv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --top-module tb_rv_core -f sources.f -o tb_rv_core_sim \
    && ./obj_dir/tb_rv_core_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "Result: FAILED" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "Result: PASSED" sim.log || { echo "no pass message in sim.log"; exit 1; }
exit 0
